//--- Makefile
TOP := tb_dma_read

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): dma_read_top.f *.sv
	verilator --binary --timing --assert -Wno-fatal -f dma_read_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then echo "Simulation ended without a result"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f dma_read_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- dma_csr.sv
// DMA configuration registers: decodes writes, holds start, length and command, acks each write
`timescale 1ns/1ns

module dma_csr
	import dma_read_pkg::*;
(
	input  logic    target_clk,
	input  logic    target_rst_b,
	input  cfg_wr_t cfg,
	output logic    cfg_ack,
	output addr_t   start_addr,
	output addr_t   len,
	output cmd_e    cmd,
	output logic    cmd_written,
	input  logic    cmd_consumed
);

	logic wr_start;
	logic wr_len;
	logic wr_cmd;

	// Offset decode, unknown offsets fall through and are only acked
	assign wr_start = cfg.valid && (cfg.addr == reg_start_addr);
	assign wr_len   = cfg.valid && (cfg.addr == reg_len);
	assign wr_cmd   = cfg.valid && (cfg.addr == reg_command);

	// Every write is acked on the following clock
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			cfg_ack <= 1'b0;
		end else begin
			cfg_ack <= cfg.valid;
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			start_addr <= '0;
			len        <= '0;
		end else begin
			if (wr_start) begin
				start_addr <= cfg.data;
			end
			if (wr_len) begin
				len <= cfg.data;
			end
		end
	end

	// A fresh write wins over the engine clearing a taken trigger_once
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			cmd         <= cmd_stop;
			cmd_written <= 1'b0;
		end else begin
			cmd_written <= wr_cmd;
			if (wr_cmd) begin
				cmd <= cmd_e'(cfg.data[1:0]);
			end else if (cmd_consumed && (cmd == cmd_trigger_once)) begin
				cmd <= cmd_stop;
			end
		end
	end

endmodule

//--- dma_fifo.sv
// DMA word FIFO with burst space reservation and a registered user pop port
`timescale 1ns/1ns

module dma_fifo
	import dma_read_pkg::*;
#(
	parameter int fifo_depth = 32
) (
	input  logic  target_clk,
	input  logic  target_rst_b,
	input  logic  push,
	input  data_t push_data,
	input  logic  reserve,
	output logic  fifo_space_ok,
	input  logic  request,
	output data_t data,
	output logic  data_ready,
	output logic  fifo_empty
);

	localparam int aw = $clog2(fifo_depth);

	data_t         mem [fifo_depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0]   count;
	logic [aw:0]   resv;
	logic [aw+1:0] used;
	logic          pop;

	assign pop        = request && !fifo_empty;
	assign fifo_empty = (count == '0);

	// Stored plus promised words must leave room for one more burst
	assign used          = count + resv;
	assign fifo_space_ok = (used <= (aw + 2)'(fifo_depth - burst_beats));

	always_ff @(posedge target_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Reservation rises by a burst on request and drains one per beat
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			resv <= '0;
		end else begin
			resv <= resv + (reserve ? (aw + 1)'(burst_beats) : '0) - (push ? 1'b1 : 1'b0);
		end
	end

	// Pop port
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			data_ready <= 1'b0;
		end else begin
			data_ready <= pop;
		end
	end

	always_ff @(posedge target_clk) begin
		if (pop) begin
			data <= mem[rd_ptr];
		end
	end

endmodule

//--- dma_read_checker.sv
// DMA read bus protocol checker: credit use, single outstanding burst, pop from empty FIFO
`timescale 1ns/1ns

module dma_read_checker
	import dma_read_pkg::*;
#(
	parameter int   initial_credits = 2,
	parameter did_t dma_did         = 4'd3
) (
	input logic      target_clk,
	input logic      target_rst_b,
	input bus_req_t  bus_req,
	input logic      credit_return,
	input bus_resp_t bus_resp,
	input logic      request,
	input logic      fifo_empty,
	input logic      data_ready
);

	int credits;
	int beats_left;

	// Own view of the credit pool and of the burst in flight
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			credits    <= initial_credits;
			beats_left <= 0;
		end else begin
			credits <= credits - int'(bus_req.valid) + int'(credit_return);
			if (bus_req.valid) begin
				beats_left <= burst_beats;
			end else if (bus_resp.valid && (bus_resp.did == dma_did) && (beats_left > 0)) begin
				beats_left <= beats_left - 1;
			end
		end
	end

	a_credit_available: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		bus_req.valid |-> (credits > 0))
		else $error("bus request issued with no credit left");

	a_single_burst: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		bus_req.valid |-> (beats_left == 0))
		else $error("second bus request before the eighth beat of the first");

	a_no_empty_pop: assert property (@(posedge target_clk) disable iff (!target_rst_b)
		(fifo_empty && request) |=> !data_ready)
		else $error("data_ready after a pop request on an empty FIFO");

endmodule

bind dma_read_top dma_read_checker #(
	.initial_credits (initial_credits),
	.dma_did         (dma_did)
) i_checker (
	.target_clk    (target_clk),
	.target_rst_b  (target_rst_b),
	.bus_req       (bus_req),
	.credit_return (credit_return),
	.bus_resp      (bus_resp),
	.request       (request),
	.fifo_empty    (fifo_empty),
	.data_ready    (data_ready)
);

//--- dma_read_engine.sv
// DMA burst read engine: credit tracking, address walk, beat counting and trigger control
`timescale 1ns/1ns

module dma_read_engine
	import dma_read_pkg::*;
#(
	parameter int   initial_credits = 2,
	parameter did_t dma_did         = 4'd3
) (
	input  logic       target_clk,
	input  logic       target_rst_b,
	input  addr_t      start_addr,
	input  addr_t      len,
	input  cmd_e       cmd,
	input  logic       cmd_written,
	output logic       cmd_consumed,
	output bus_req_t   bus_req,
	input  logic       credit_return,
	input  bus_resp_t  bus_resp,
	input  logic       fifo_space_ok,
	output logic       reserve,
	output logic       push,
	output data_t      push_data,
	output logic       busy
);

	localparam int credit_w = $clog2(initial_credits + 1);
	localparam int beat_w   = $clog2(burst_beats);

	eng_state_e          state;
	logic [credit_w-1:0] credits;
	logic [beat_w-1:0]   beat_cnt;
	addr_t               cur_addr;
	addr_t               end_addr;
	addr_t               next_addr;
	logic                armed;
	logic                start_req;
	logic                beat_hit;
	logic                last_beat;
	logic                pass_done;
	logic                take;
	logic                issue_ok;

	// Credits: one spent per request strobe, one back per return cycle
	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			credits <= credit_w'(initial_credits);
		end else begin
			case ({credit_return, bus_req.valid})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// Trigger is live on the write pulse itself or while still armed
	assign start_req = (cmd_written || armed) &&
		((cmd == cmd_trigger_once) || (cmd == cmd_autotrigger));

	// Only beats for our own ID count, and only while a burst is out
	assign beat_hit  = (state == st_wait) && bus_resp.valid && (bus_resp.did == dma_did);
	assign last_beat = beat_hit && (beat_cnt == beat_w'(burst_beats - 1));
	assign next_addr = cur_addr + addr_t'(burst_bytes);
	assign pass_done = (next_addr >= end_addr);

	// Start points: idle, or the end of a pass
	assign take         = start_req && ((state == st_idle) || (last_beat && pass_done));
	assign cmd_consumed = take && (cmd == cmd_trigger_once);

	// State implies no burst is pending here
	assign issue_ok = (state == st_issue) && (credits != '0) && fifo_space_ok;

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			armed <= 1'b0;
		end else if (cmd_consumed) begin
			armed <= 1'b0;
		end else if (cmd_written) begin
			armed <= (cmd != cmd_stop);
		end
	end

	always_ff @(posedge target_clk or negedge target_rst_b) begin
		if (!target_rst_b) begin
			state    <= st_idle;
			beat_cnt <= '0;
			cur_addr <= '0;
			end_addr <= '0;
			bus_req  <= '0;
		end else begin
			bus_req.valid <= 1'b0;
			case (state)
				st_idle: begin
					if (take) begin
						cur_addr <= start_addr;
						end_addr <= start_addr + len;
						state    <= st_issue;
					end
				end
				st_issue: begin
					if (issue_ok) begin
						bus_req  <= '{valid: 1'b1, did: dma_did, addr: cur_addr};
						beat_cnt <= '0;
						state    <= st_wait;
					end
				end
				st_wait: begin
					if (beat_hit) begin
						beat_cnt <= beat_cnt + 1'b1;
					end
					if (last_beat) begin
						if (!pass_done) begin
							cur_addr <= next_addr;
							state    <= st_issue;
						end else if (take) begin
							// Autotrigger or a queued command restarts at once
							cur_addr <= start_addr;
							end_addr <= start_addr + len;
							state    <= st_issue;
						end else begin
							state <= st_idle;
						end
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// FIFO space is claimed together with the request
	assign reserve   = bus_req.valid;
	assign push      = beat_hit;
	assign push_data = bus_resp.data;
	assign busy      = (state != st_idle);

endmodule

//--- dma_read_pkg.sv
// DMA read controller shared package: widths, commands, FSM states, register map, bus structs
package dma_read_pkg;

	// Widths with a meaning on the bus and the config port
	typedef logic [31:0] addr_t;
	typedef logic [63:0] data_t;
	typedef logic [3:0]  did_t;
	typedef logic [3:0]  cfg_addr_t;

	// Command register encoding
	typedef enum logic [1:0] {
		cmd_stop         = 2'd0,
		cmd_trigger_once = 2'd1,
		cmd_autotrigger  = 2'd2
	} cmd_e;

	// Read engine FSM
	typedef enum logic [1:0] {
		st_idle  = 2'd0,
		st_issue = 2'd1,
		st_wait  = 2'd2
	} eng_state_e;

	// Register offsets
	localparam cfg_addr_t reg_start_addr = 4'h0;
	localparam cfg_addr_t reg_len        = 4'h4;
	localparam cfg_addr_t reg_command    = 4'h8;

	// One burst is a 64-byte line, eight 64-bit beats
	localparam int burst_beats = 8;
	localparam int burst_bytes = 64;

	// Read request towards the bus, valid is a single-cycle strobe
	typedef struct packed {
		logic  valid;
		did_t  did;
		addr_t addr;
	} bus_req_t;

	// Returned read beat
	typedef struct packed {
		logic  valid;
		did_t  did;
		data_t data;
	} bus_resp_t;

	// Configuration write
	typedef struct packed {
		logic      valid;
		cfg_addr_t addr;
		addr_t     data;
	} cfg_wr_t;

endpackage

//--- dma_read_top.f
dma_read_pkg.sv
dma_csr.sv
dma_read_engine.sv
dma_fifo.sv
dma_read_top.sv
tb_fsab_mem.sv
dma_read_checker.sv
tb_dma_read.sv

//--- dma_read_top.sv
// DMA read controller top: register block, burst read engine and word FIFO
`timescale 1ns/1ns

module dma_read_top
	import dma_read_pkg::*;
#(
	parameter int   fifo_depth      = 32,
	parameter int   initial_credits = 2,
	parameter did_t dma_did         = 4'd3
) (
	input  logic      target_clk,
	input  logic      target_rst_b,
	input  cfg_wr_t   cfg,
	output logic      cfg_ack,
	output bus_req_t  bus_req,
	input  logic      credit_return,
	input  bus_resp_t bus_resp,
	input  logic      request,
	output data_t     data,
	output logic      data_ready,
	output logic      fifo_empty,
	output logic      busy
);

	addr_t start_addr;
	addr_t len;
	cmd_e  cmd;
	logic  cmd_written;
	logic  cmd_consumed;
	logic  fifo_space_ok;
	logic  reserve;
	logic  push;
	data_t push_data;

	dma_csr i_csr (
		.target_clk   (target_clk),
		.target_rst_b (target_rst_b),
		.cfg          (cfg),
		.cfg_ack      (cfg_ack),
		.start_addr   (start_addr),
		.len          (len),
		.cmd          (cmd),
		.cmd_written  (cmd_written),
		.cmd_consumed (cmd_consumed)
	);

	dma_read_engine #(
		.initial_credits (initial_credits),
		.dma_did         (dma_did)
	) i_engine (
		.target_clk    (target_clk),
		.target_rst_b  (target_rst_b),
		.start_addr    (start_addr),
		.len           (len),
		.cmd           (cmd),
		.cmd_written   (cmd_written),
		.cmd_consumed  (cmd_consumed),
		.bus_req       (bus_req),
		.credit_return (credit_return),
		.bus_resp      (bus_resp),
		.fifo_space_ok (fifo_space_ok),
		.reserve       (reserve),
		.push          (push),
		.push_data     (push_data),
		.busy          (busy)
	);

	dma_fifo #(
		.fifo_depth (fifo_depth)
	) i_fifo (
		.target_clk    (target_clk),
		.target_rst_b  (target_rst_b),
		.push          (push),
		.push_data     (push_data),
		.reserve       (reserve),
		.fifo_space_ok (fifo_space_ok),
		.request       (request),
		.data          (data),
		.data_ready    (data_ready),
		.fifo_empty    (fifo_empty)
	);

endmodule

//--- tb_dma_read.sv
// DMA read controller testbench: directed tests over config port, bus model and pop port
`timescale 1ns/1ns

module tb_dma_read
	import dma_read_pkg::*;
();

	localparam int fifo_depth  = 32;
	// Beats of all tests, autotrigger counted as four passes
	localparam int total_beats = 32 + 64 + 48 + 32 + 32;

	logic        target_clk = 1'b0;
	logic        target_rst_b = 1'b0;
	cfg_wr_t     cfg = '0;
	logic        request = 1'b0;
	logic        foreign_en = 1'b0;
	logic        credit_return;
	bus_resp_t   bus_resp;
	bus_req_t    bus_req;
	logic        cfg_ack;
	logic        data_ready;
	logic        fifo_empty;
	logic        busy;
	data_t       data;
	logic [15:0] lfsr_state = 16'd59;

	always #20 target_clk = ~target_clk;

	dma_read_top #(
		.fifo_depth      (fifo_depth),
		.initial_credits (2),
		.dma_did         (4'd3)
	) i_dut (
		.target_clk    (target_clk),
		.target_rst_b  (target_rst_b),
		.cfg           (cfg),
		.cfg_ack       (cfg_ack),
		.bus_req       (bus_req),
		.credit_return (credit_return),
		.bus_resp      (bus_resp),
		.request       (request),
		.data          (data),
		.data_ready    (data_ready),
		.fifo_empty    (fifo_empty),
		.busy          (busy)
	);

	tb_fsab_mem i_mem (
		.target_clk    (target_clk),
		.target_rst_b  (target_rst_b),
		.bus_req       (bus_req),
		.foreign_en    (foreign_en),
		.credit_return (credit_return),
		.bus_resp      (bus_resp)
	);

	function automatic logic next_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 16'hB400;
		end
		return lsb;
	endfunction

	// Memory rule: address in the upper word, inverted address in the lower
	function automatic data_t expected_word(input addr_t a);
		return {a, ~a};
	endfunction

	task automatic end_with_failure();
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("ERR %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end_with_failure();
	endtask

	task automatic report_fault(input string what);
		$display("Error at %0t ns: %s", $time, what);
		end_with_failure();
	endtask

	task automatic cfg_write(input cfg_addr_t a, input addr_t d);
		@(negedge target_clk);
		assert (!cfg_ack) else report_mismatch("cfg_ack", cfg_ack, 0);
		cfg = '{valid: 1'b1, addr: a, data: d};
		@(negedge target_clk);
		cfg = '0;
		assert (cfg_ack) else report_mismatch("cfg_ack", cfg_ack, 1);
	endtask

	// Pops n words and checks them against the running address
	task automatic pop_and_check(input int n, input addr_t base, input bit rand_pop);
		int    got;
		addr_t a;
		logic  empty_req;
		got = 0;
		a = base;
		empty_req = 1'b0;
		while (got < n) begin
			@(negedge target_clk);
			assert (!(data_ready && empty_req))
				else report_fault("data_ready rose after a pop from an empty FIFO");
			if (data_ready) begin
				assert (data == expected_word(a)) else report_mismatch("data", data, expected_word(a));
				got++;
				a = a + 32'd8;
			end
			request = rand_pop ? next_bit() : 1'b1;
			empty_req = fifo_empty && request;
		end
		request = 1'b0;
	endtask

	task automatic wait_idle();
		while (busy) begin
			@(negedge target_clk);
		end
	endtask

	task automatic expect_quiet(input int cycles);
		int i;
		for (i = 0; i < cycles; i++) begin
			@(negedge target_clk);
			assert (!bus_req.valid) else report_fault("bus request after the transfer ended");
			assert (!busy) else report_mismatch("busy", busy, 0);
			assert (!data_ready) else report_mismatch("data_ready", data_ready, 0);
			assert (fifo_empty) else report_mismatch("fifo_empty", fifo_empty, 1);
		end
	endtask

	task automatic reset_state_test();
		@(negedge target_clk);
		assert (!busy) else report_mismatch("busy", busy, 0);
		assert (!data_ready) else report_mismatch("data_ready", data_ready, 0);
		assert (!cfg_ack) else report_mismatch("cfg_ack", cfg_ack, 0);
		assert (fifo_empty) else report_mismatch("fifo_empty", fifo_empty, 1);
		assert (!bus_req.valid) else report_mismatch("bus_req.valid", bus_req.valid, 0);
		// Unknown offset, still acked
		cfg_write(4'hC, 32'h5A5A_0000);
		expect_quiet(4);
	endtask

	task automatic run_once(input addr_t base, input int bursts, input bit rand_pop);
		cfg_write(reg_start_addr, base);
		cfg_write(reg_len, addr_t'(bursts * burst_bytes));
		cfg_write(reg_command, addr_t'(cmd_trigger_once));
		pop_and_check(bursts * burst_beats, base, rand_pop);
		wait_idle();
		expect_quiet(40);
	endtask

	task automatic autotrigger_stop_test();
		int    got;
		addr_t a;
		bit    stopped;
		bit    done;
		got = 0;
		a = 32'h2000;
		stopped = 1'b0;
		done = 1'b0;
		cfg_write(reg_start_addr, 32'h2000);
		cfg_write(reg_len, addr_t'(2 * burst_bytes));
		cfg_write(reg_command, addr_t'(cmd_autotrigger));
		request = 1'b1;
		while (!done) begin
			@(negedge target_clk);
			cfg = '0;
			if (data_ready) begin
				assert (data == expected_word(a)) else report_mismatch("data", data, expected_word(a));
				got++;
				a = (a + 32'd8 == 32'h2000 + 2 * burst_bytes) ? 32'h2000 : a + 32'd8;
			end
			if (!stopped && (got >= 40)) begin
				cfg = '{valid: 1'b1, addr: reg_command, data: addr_t'(cmd_stop)};
				stopped = 1'b1;
			end else if (stopped && !busy && fifo_empty && !data_ready) begin
				done = 1'b1;
			end
		end
		request = 1'b0;
		assert (got % (2 * burst_beats) == 0)
			else report_fault("autotrigger stopped in the middle of a pass");
		expect_quiet(60);
	endtask

	task automatic backpressure_test();
		int    reqs;
		int    i;
		addr_t exp_addr;
		reqs = 0;
		request = 1'b0;
		cfg_write(reg_start_addr, 32'h4000);
		cfg_write(reg_len, addr_t'(6 * burst_bytes));
		cfg_write(reg_command, addr_t'(cmd_trigger_once));
		for (i = 0; i < 400; i++) begin
			@(negedge target_clk);
			if (bus_req.valid) begin
				// Bursts walk the region in 64-byte steps under our own ID
				exp_addr = 32'h4000 + addr_t'(reqs * burst_bytes);
				assert (bus_req.did == 4'd3)
					else report_mismatch("bus_req.did", bus_req.did, 4'd3);
				assert (bus_req.addr == exp_addr)
					else report_mismatch("bus_req.addr", bus_req.addr, exp_addr);
				reqs++;
			end
		end
		// Only as many bursts as the FIFO can hold
		assert (reqs == fifo_depth / burst_beats)
			else report_mismatch("bus_req count", reqs, fifo_depth / burst_beats);
		assert (busy) else report_fault("engine went idle with the transfer unfinished");
		pop_and_check(6 * burst_beats, 32'h4000, 1'b0);
		wait_idle();
		expect_quiet(40);
	endtask

	initial begin
		#((total_beats * 20 + 2000) * 40);
		$display("Watchdog expired before the tests finished");
		end_with_failure();
	end

	initial begin
		repeat (16) @(posedge target_clk);
		@(negedge target_clk);
		target_rst_b = 1'b1;
		reset_state_test();
		run_once(32'h1000, 4, 1'b0);
		autotrigger_stop_test();
		backpressure_test();
		foreign_en = 1'b1;
		run_once(32'h1000, 4, 1'b0);
		foreign_en = 1'b0;
		run_once(32'h6000, 4, 1'b1);
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- tb_fsab_mem.sv
// Bus memory model: answers read bursts with address-derived beats and returns credits
`timescale 1ns/1ns

module tb_fsab_mem
	import dma_read_pkg::*;
(
	input  logic      target_clk,
	input  logic      target_rst_b,
	input  bus_req_t  bus_req,
	input  logic      foreign_en,
	output logic      credit_return,
	output bus_resp_t bus_resp
);

	logic [15:0] lfsr_state = 16'd59;
	logic        active = 1'b0;
	logic        credit_due = 1'b0;
	logic        ret_q = 1'b0;
	bus_resp_t   resp_q = '0;
	int          delay;
	int          credit_delay;
	int          beat;
	addr_t       base;
	addr_t       beat_addr;
	did_t        req_did;

	assign credit_return = ret_q;
	assign bus_resp      = resp_q;

	// Galois LFSR, one step per bit taken
	function automatic logic next_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 16'hB400;
		end
		return lsb;
	endfunction

	function automatic int take_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			v = (v << 1) | int'(next_bit());
		end
		return v;
	endfunction

	// Responses change on the falling edge
	always @(negedge target_clk) begin
		resp_q <= '0;
		ret_q  <= 1'b0;
		if (!target_rst_b) begin
			active     <= 1'b0;
			credit_due <= 1'b0;
		end else begin
			if (credit_due) begin
				if (credit_delay <= 1) begin
					ret_q      <= 1'b1;
					credit_due <= 1'b0;
				end else begin
					credit_delay <= credit_delay - 1;
				end
			end
			if (bus_req.valid) begin
				base         <= bus_req.addr;
				req_did      <= bus_req.did;
				beat         <= 0;
				delay        <= 2 + take_bits(3);
				credit_delay <= 1 + take_bits(2);
				active       <= 1'b1;
				credit_due   <= 1'b1;
			end else if (active) begin
				if (delay != 0) begin
					delay <= delay - 1;
				end else if (foreign_en && (take_bits(3) == 0)) begin
					// Stray beat for another device
					resp_q <= '{valid: 1'b1, did: 4'd5, data: {addr_t'(beat), 32'hDEAD_BEEF}};
				end else begin
					beat_addr = base + addr_t'(beat * 8);
					resp_q <= '{valid: 1'b1, did: req_did, data: {beat_addr, ~beat_addr}};
					beat   <= beat + 1;
					if (beat == burst_beats - 1) begin
						active <= 1'b0;
					end
				end
			end
		end
	end

endmodule
